// ==== pkt_filter.f ====
+incdir+rtl
rtl/pkt_stream_pkg.sv
rtl/pkt_stats_pkg.sv
rtl/pkt_classify.sv
rtl/pkt_drop.sv
rtl/pkt_probe.sv
rtl/stream_pipe.sv
rtl/pkt_filter_top.sv
testbench/pkt_filter_properties.sv
testbench/pkt_filter_tb.sv

// ==== rtl/pkt_classify.sv ====
/*
 * Classification stage.
 * One word pipeline register that flags blocked packets on their first word.
 */

`include "pkt_filter_defines.svh"

module pkt_classify (
   input  logic                         clk,
   input  logic                         srst,

   input  logic                         in_tvalid,
   output logic                         in_tready,
   input  pkt_stream_pkg::pkt_data_t    in_tdata,
   input  pkt_stream_pkg::pkt_keep_t    in_tkeep,
   input  logic                         in_tlast,
   input  pkt_stream_pkg::pkt_id_t      in_tid,
   input  pkt_stream_pkg::pkt_dest_t    in_tdest,

   input  logic [2**`PKT_DEST_WID-1:0]  block_mask,

   output logic                         out_tvalid,
   input  logic                         out_tready,
   output pkt_stream_pkg::pkt_data_t    out_tdata,
   output pkt_stream_pkg::pkt_keep_t    out_tkeep,
   output logic                         out_tlast,
   output pkt_stream_pkg::pkt_id_t      out_tid,
   output pkt_stream_pkg::pkt_dest_t    out_tdest,

   output logic                         drop_pkt
);

   logic in_fire;
   logic sop_next;    // next input word starts a packet.
   logic out_first;   // held word is the first of its packet.

   assign in_tready = !out_tvalid || out_tready;
   assign in_fire   = in_tvalid && in_tready;

   // --------------------
   // pipeline register.
   // --------------------
   always_ff @(posedge clk) begin
      if (srst) begin
         out_tvalid <= 1'b0;
      end else if (in_tready) begin
         out_tvalid <= in_tvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         out_tdata <= in_tdata;
         out_tkeep <= in_tkeep;
         out_tlast <= in_tlast;
         out_tid   <= in_tid;
         out_tdest <= in_tdest;
      end
   end

   // --------------------
   // first word tracking.
   // --------------------
   // follows this stage's own tlast transfers, so stalls do not upset it.
   always_ff @(posedge clk) begin
      if (srst) begin
         sop_next  <= 1'b1;
         out_first <= 1'b0;
      end else if (in_fire) begin
         sop_next  <= in_tlast;
         out_first <= sop_next;
      end
   end

   assign drop_pkt = out_tvalid && out_first && block_mask[out_tdest];

endmodule

// ==== rtl/pkt_drop.sv ====
/*
 * Drop stage.
 * Removes every word of a flagged packet and drives the drop probe tap.
 */

module pkt_drop (
   input  logic                       clk,
   input  logic                       srst,

   input  logic                       in_tvalid,
   output logic                       in_tready,
   input  pkt_stream_pkg::pkt_data_t  in_tdata,
   input  pkt_stream_pkg::pkt_keep_t  in_tkeep,
   input  logic                       in_tlast,
   input  pkt_stream_pkg::pkt_id_t    in_tid,
   input  pkt_stream_pkg::pkt_dest_t  in_tdest,

   output logic                       out_tvalid,
   input  logic                       out_tready,
   output pkt_stream_pkg::pkt_data_t  out_tdata,
   output pkt_stream_pkg::pkt_keep_t  out_tkeep,
   output logic                       out_tlast,
   output pkt_stream_pkg::pkt_id_t    out_tid,
   output pkt_stream_pkg::pkt_dest_t  out_tdest,

   input  logic                       drop_pkt,

   output logic                       tap_valid,
   output pkt_stream_pkg::pkt_keep_t  tap_keep,
   output logic                       tap_last
);

   logic drop_latch;
   logic drop;

   // holds the drop through the rest of the packet.
   always_ff @(posedge clk) begin
      if (srst) begin
         drop_latch <= 1'b0;
      end else if (in_tvalid && in_tready && in_tlast) begin
         drop_latch <= 1'b0;
      end else if (drop_pkt) begin
         drop_latch <= 1'b1;
      end
   end

   assign drop = drop_pkt || drop_latch;

   // dropped words are taken at full rate whatever the output does.
   assign in_tready  = out_tready || drop;
   assign out_tvalid = in_tvalid && !drop;
   assign out_tdata  = in_tdata;
   assign out_tkeep  = in_tkeep;
   assign out_tlast  = in_tlast;
   assign out_tid    = in_tid;
   assign out_tdest  = in_tdest;

   // in_tready is high while dropping, so valid alone marks acceptance.
   assign tap_valid = in_tvalid && drop;
   assign tap_keep  = in_tkeep;
   assign tap_last  = in_tlast;

endmodule

// ==== rtl/pkt_filter_defines.svh ====
/*
 * Width macros for the packet filter.
 * Stream word size, sideband field widths and counter width.
 */

`ifndef PKT_FILTER_DEFINES_SVH
`define PKT_FILTER_DEFINES_SVH

// bytes carried by one stream word.
`define PKT_DATA_BYTES 8

`define PKT_DEST_WID 4
`define PKT_ID_WID 4

// statistics counters wrap at this width.
`define PKT_CNT_WID 32

`endif

// ==== rtl/pkt_filter_top.sv ====
/*
 * Packet filter top level.
 * Classify, drop and output slice in a chain, with the drop probe on the side.
 */

`include "pkt_filter_defines.svh"

module pkt_filter_top #(
   parameter pkt_stream_pkg::pipe_mode_t OUT_PIPE_MODE = pkt_stream_pkg::PULL
) (
   input  logic                         clk,
   input  logic                         srst,

   input  logic                         in_tvalid,
   output logic                         in_tready,
   input  pkt_stream_pkg::pkt_data_t    in_tdata,
   input  pkt_stream_pkg::pkt_keep_t    in_tkeep,
   input  logic                         in_tlast,
   input  pkt_stream_pkg::pkt_id_t      in_tid,
   input  pkt_stream_pkg::pkt_dest_t    in_tdest,

   output logic                         out_tvalid,
   input  logic                         out_tready,
   output pkt_stream_pkg::pkt_data_t    out_tdata,
   output pkt_stream_pkg::pkt_keep_t    out_tkeep,
   output logic                         out_tlast,
   output pkt_stream_pkg::pkt_id_t      out_tid,
   output pkt_stream_pkg::pkt_dest_t    out_tdest,

   input  logic [2**`PKT_DEST_WID-1:0]  block_mask,

   input  logic                         reg_rd,
   input  pkt_stats_pkg::stat_reg_t     reg_addr,
   output pkt_stats_pkg::stat_cnt_t     reg_rdata,
   output logic                         reg_rdata_valid
);

   import pkt_stream_pkg::*;

   // --------------------
   // classify to drop.
   // --------------------
   logic       c_tvalid, c_tready, c_tlast, drop_pkt;
   pkt_data_t  c_tdata;
   pkt_keep_t  c_tkeep;
   pkt_id_t    c_tid;
   pkt_dest_t  c_tdest;

   // --------------------
   // drop to output slice.
   // --------------------
   logic       d_tvalid, d_tready, d_tlast;
   pkt_data_t  d_tdata;
   pkt_keep_t  d_tkeep;
   pkt_id_t    d_tid;
   pkt_dest_t  d_tdest;

   // probe tap.
   logic       tap_valid, tap_last;
   pkt_keep_t  tap_keep;

   pkt_classify u_classify (
      .clk, .srst,
      .in_tvalid, .in_tready, .in_tdata, .in_tkeep, .in_tlast, .in_tid, .in_tdest,
      .block_mask,
      .out_tvalid (c_tvalid), .out_tready (c_tready), .out_tdata (c_tdata),
      .out_tkeep  (c_tkeep),  .out_tlast  (c_tlast),  .out_tid   (c_tid),
      .out_tdest  (c_tdest),
      .drop_pkt
   );

   pkt_drop u_drop (
      .clk, .srst,
      .in_tvalid  (c_tvalid), .in_tready  (c_tready), .in_tdata  (c_tdata),
      .in_tkeep   (c_tkeep),  .in_tlast   (c_tlast),  .in_tid    (c_tid),
      .in_tdest   (c_tdest),
      .out_tvalid (d_tvalid), .out_tready (d_tready), .out_tdata (d_tdata),
      .out_tkeep  (d_tkeep),  .out_tlast  (d_tlast),  .out_tid   (d_tid),
      .out_tdest  (d_tdest),
      .drop_pkt,
      .tap_valid, .tap_keep, .tap_last
   );

   pkt_probe u_probe (
      .clk, .srst,
      .tap_valid, .tap_keep, .tap_last,
      .reg_rd, .reg_addr, .reg_rdata, .reg_rdata_valid
   );

   stream_pipe #(.MODE(OUT_PIPE_MODE)) u_out_pipe (
      .clk, .srst,
      .in_tvalid  (d_tvalid), .in_tready  (d_tready), .in_tdata  (d_tdata),
      .in_tkeep   (d_tkeep),  .in_tlast   (d_tlast),  .in_tid    (d_tid),
      .in_tdest   (d_tdest),
      .out_tvalid, .out_tready, .out_tdata, .out_tkeep, .out_tlast, .out_tid, .out_tdest
   );

endmodule

// ==== rtl/pkt_probe.sv ====
/*
 * Drop probe.
 * Counts dropped packets and dropped bytes, serves register reads.
 */

`include "pkt_filter_defines.svh"

module pkt_probe (
   input  logic                       clk,
   input  logic                       srst,

   input  logic                       tap_valid,
   input  pkt_stream_pkg::pkt_keep_t  tap_keep,
   input  logic                       tap_last,

   input  logic                       reg_rd,
   input  pkt_stats_pkg::stat_reg_t   reg_addr,
   output pkt_stats_pkg::stat_cnt_t   reg_rdata,
   output logic                       reg_rdata_valid
);

   import pkt_stats_pkg::*;

   stat_cnt_t                             drop_pkts;
   stat_cnt_t                             drop_bytes;
   logic [$clog2(`PKT_DATA_BYTES+1)-1:0]  keep_cnt;

   // number of valid bytes in the tapped word.
   always_comb begin
      keep_cnt = '0;
      for (int i = 0; i < `PKT_DATA_BYTES; i++) begin
         keep_cnt = keep_cnt + tap_keep[i];
      end
   end

   // --------------------
   // counters.
   // --------------------
   // both wrap, there is no clear.
   always_ff @(posedge clk) begin
      if (srst) begin
         drop_pkts  <= '0;
         drop_bytes <= '0;
      end else if (tap_valid) begin
         drop_bytes <= drop_bytes + stat_cnt_t'(keep_cnt);
         if (tap_last) begin
            drop_pkts <= drop_pkts + 1'b1;
         end
      end
   end

   // --------------------
   // register read.
   // --------------------
   always_ff @(posedge clk) begin
      if (srst) begin
         reg_rdata_valid <= 1'b0;
      end else begin
         reg_rdata_valid <= reg_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_rd) begin
         case (reg_addr)
            REG_DROP_PKTS:  reg_rdata <= drop_pkts;
            REG_DROP_BYTES: reg_rdata <= drop_bytes;
            default:        reg_rdata <= '0;
         endcase
      end
   end

endmodule

// ==== rtl/pkt_stats_pkg.sv ====
/*
 * Statistics types.
 * Drop counter type and the register address map.
 */

`include "pkt_filter_defines.svh"

package pkt_stats_pkg;

   typedef logic [`PKT_CNT_WID-1:0] stat_cnt_t;

   // register map of the drop probe.
   typedef enum logic {
      REG_DROP_PKTS  = 1'b0,
      REG_DROP_BYTES = 1'b1
   } stat_reg_t;

endpackage

// ==== rtl/pkt_stream_pkg.sv ====
/*
 * Packet stream types.
 * Data, keep, destination and id fields, and the output slice mode.
 */

`include "pkt_filter_defines.svh"

package pkt_stream_pkg;

   typedef logic [`PKT_DATA_BYTES*8-1:0] pkt_data_t;
   typedef logic [`PKT_DATA_BYTES-1:0]   pkt_keep_t;
   typedef logic [`PKT_DEST_WID-1:0]     pkt_dest_t;
   typedef logic [`PKT_ID_WID-1:0]       pkt_id_t;

   // PULL passes ready back combinationally.
   // PUSH is a two entry skid with registered ready.
   typedef enum logic {
      PULL = 1'b0,
      PUSH = 1'b1
   } pipe_mode_t;

endpackage

// ==== rtl/stream_pipe.sv ====
/*
 * Output register slice.
 * PULL mode is one register, PUSH mode is a main register plus skid.
 */

module stream_pipe #(
   parameter pkt_stream_pkg::pipe_mode_t MODE = pkt_stream_pkg::PULL
) (
   input  logic                       clk,
   input  logic                       srst,

   input  logic                       in_tvalid,
   output logic                       in_tready,
   input  pkt_stream_pkg::pkt_data_t  in_tdata,
   input  pkt_stream_pkg::pkt_keep_t  in_tkeep,
   input  logic                       in_tlast,
   input  pkt_stream_pkg::pkt_id_t    in_tid,
   input  pkt_stream_pkg::pkt_dest_t  in_tdest,

   output logic                       out_tvalid,
   input  logic                       out_tready,
   output pkt_stream_pkg::pkt_data_t  out_tdata,
   output pkt_stream_pkg::pkt_keep_t  out_tkeep,
   output logic                       out_tlast,
   output pkt_stream_pkg::pkt_id_t    out_tid,
   output pkt_stream_pkg::pkt_dest_t  out_tdest
);

   import pkt_stream_pkg::*;

   logic main_free;

   assign main_free = !out_tvalid || out_tready;

   if (MODE == PULL) begin : g_pull
      assign in_tready = main_free;

      always_ff @(posedge clk) begin
         if (srst) begin
            out_tvalid <= 1'b0;
         end else if (main_free) begin
            out_tvalid <= in_tvalid;
         end
      end

      always_ff @(posedge clk) begin
         if (in_tvalid && main_free) begin
            {out_tdata, out_tkeep, out_tlast, out_tid, out_tdest} <=
               {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest};
         end
      end
   end else begin : g_push
      logic       skid_valid;
      pkt_data_t  skid_tdata;
      pkt_keep_t  skid_tkeep;
      logic       skid_tlast;
      pkt_id_t    skid_tid;
      pkt_dest_t  skid_tdest;

      // ready is the registered emptiness of the skid.
      assign in_tready = !skid_valid;

      always_ff @(posedge clk) begin
         if (srst) begin
            out_tvalid <= 1'b0;
            skid_valid <= 1'b0;
         end else if (main_free) begin
            out_tvalid <= skid_valid || in_tvalid;
            skid_valid <= 1'b0;
         end else if (in_tvalid && in_tready) begin
            skid_valid <= 1'b1;
         end
      end

      // the skid word is older than any input word, so it moves first.
      always_ff @(posedge clk) begin
         if (main_free) begin
            if (skid_valid) begin
               {out_tdata, out_tkeep, out_tlast, out_tid, out_tdest} <=
                  {skid_tdata, skid_tkeep, skid_tlast, skid_tid, skid_tdest};
            end else begin
               {out_tdata, out_tkeep, out_tlast, out_tid, out_tdest} <=
                  {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest};
            end
         end else if (in_tvalid && in_tready) begin
            {skid_tdata, skid_tkeep, skid_tlast, skid_tid, skid_tdest} <=
               {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest};
         end
      end
   end

endmodule

// ==== testbench/pkt_filter_patterns.txt ====
# T <block_mask hex> <out_tready stall percent> <packet count>
# P <dest hex> <id hex> <word count> <final word keep hex> <data seed hex>
T 0000 0 5
P 0 1 3 ff 00001000
P 3 2 1 0f 00001100
P 7 3 5 01 00001200
P f 4 2 7f 00001300
P 2 5 4 3f 00001400
T 0024 0 6
P 1 6 2 ff 00002000
P 2 7 3 3f 00002100
P 5 8 4 ff 00002200
P 4 9 1 03 00002300
P 2 a 2 ff 00002400
P 0 b 3 07 00002500
T 0024 0 7
P 5 c 1 0f 00003000
P 1 d 1 ff 00003100
P 2 e 1 01 00003200
P 2 f 1 ff 00003300
P 6 0 3 1f 00003400
P 5 1 1 ff 00003500
P 3 2 2 0f 00003600
T 0024 50 6
P 1 3 2 ff 00004000
P 2 4 3 3f 00004100
P 5 5 4 ff 00004200
P 4 6 1 03 00004300
P 2 7 2 ff 00004400
P 0 8 3 07 00004500
T 8101 30 5
P 0 9 2 ff 00005000
P 8 a 1 0f 00005100
P 9 b 3 ff 00005200
P f c 2 01 00005300
P 1 d 4 3f 00005400

// ==== testbench/pkt_filter_properties.sv ====
/*
 * Concurrent assertions bound to the packet filter top level.
 * Stream handshakes, register read timing and reset behaviour.
 */

module pkt_filter_properties (
   input logic                       clk,
   input logic                       srst,
   input logic                       in_tvalid,
   input logic                       in_tready,
   input logic                       out_tvalid,
   input logic                       out_tready,
   input pkt_stream_pkg::pkt_data_t  out_tdata,
   input pkt_stream_pkg::pkt_keep_t  out_tkeep,
   input logic                       out_tlast,
   input pkt_stream_pkg::pkt_id_t    out_tid,
   input pkt_stream_pkg::pkt_dest_t  out_tdest,
   input logic                       reg_rd,
   input logic                       reg_rdata_valid
);

   // a stalled output word holds until it is taken.
   a_out_hold : assert property (@(posedge clk) disable iff (srst)
      out_tvalid && !out_tready |=> out_tvalid &&
         $stable({out_tdata, out_tkeep, out_tlast, out_tid, out_tdest}))
      else $error("output word changed while stalled");

   a_in_hold : assert property (@(posedge clk) disable iff (srst)
      in_tvalid && !in_tready |=> in_tvalid)
      else $error("input valid withdrawn before its transfer");

   a_reg_valid : assert property (@(posedge clk) disable iff (srst)
      reg_rdata_valid == $past(reg_rd))
      else $error("register read data valid not one cycle after the strobe");

   a_reset_quiet : assert property (@(posedge clk)
      srst && $past(srst) |-> !out_tvalid)
      else $error("output valid during reset");

endmodule

bind pkt_filter_top pkt_filter_properties u_props (.*);

// ==== testbench/pkt_filter_tb.sv ====
/*
 * Testbench for the packet filter.
 * Clock and reset, stimulus from the pattern file, back-pressure,
 * scoreboard, drop counter reads and watchdog.
 */

`include "pkt_filter_defines.svh"

module pkt_filter_tb #(
   parameter pkt_stream_pkg::pipe_mode_t PIPE_MODE = pkt_stream_pkg::PULL
);

   import pkt_stream_pkg::*;
   import pkt_stats_pkg::*;

   localparam int CLK_PERIOD = 20;

   typedef struct {
      logic [2**`PKT_DEST_WID-1:0] mask;
      int                          stall;
      int                          first;
      int                          npkt;
   } test_desc_t;

   typedef struct {
      pkt_dest_t    dest;
      pkt_id_t      id;
      int           words;
      pkt_keep_t    last_keep;
      logic [31:0]  seed;
   } pkt_desc_t;

   typedef struct {
      pkt_data_t  data;
      pkt_keep_t  keep;
      logic       last;
      pkt_id_t    id;
      pkt_dest_t  dest;
      longint     stamp;
   } exp_word_t;

   logic                         clk;
   logic                         srst;
   logic                         in_tvalid, in_tready, in_tlast;
   pkt_data_t                    in_tdata;
   pkt_keep_t                    in_tkeep;
   pkt_id_t                      in_tid;
   pkt_dest_t                    in_tdest;
   logic                         out_tvalid, out_tready, out_tlast;
   pkt_data_t                    out_tdata;
   pkt_keep_t                    out_tkeep;
   pkt_id_t                      out_tid;
   pkt_dest_t                    out_tdest;
   logic [2**`PKT_DEST_WID-1:0]  block_mask;
   logic                         reg_rd, reg_rdata_valid;
   stat_reg_t                    reg_addr;
   stat_cnt_t                    reg_rdata;

   test_desc_t  tests[$];
   pkt_desc_t   pkts[$];
   exp_word_t   exp_q[$];
   int          total_words;
   int          stall_pct;
   stat_cnt_t   exp_drop_pkts;
   stat_cnt_t   exp_drop_bytes;

   pkt_filter_top #(.OUT_PIPE_MODE(PIPE_MODE)) u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // --------------------
   // reporting and checks.
   // --------------------
   task automatic end_with_failure(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped after an error");
   endtask

   task automatic report_mismatch(input string name, input pkt_data_t got, input pkt_data_t want);
      end_with_failure($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, want));
   endtask

   task automatic check_word(input pkt_data_t data, input pkt_keep_t keep, input logic last,
                             input pkt_id_t id, input pkt_dest_t dest, input exp_word_t want);
      if (data !== want.data) report_mismatch("out_tdata", data, want.data);
      if (keep !== want.keep) report_mismatch("out_tkeep", keep, want.keep);
      if (last !== want.last) report_mismatch("out_tlast", last, want.last);
      if (id !== want.id) report_mismatch("out_tid", id, want.id);
      if (dest !== want.dest) report_mismatch("out_tdest", dest, want.dest);
   endtask

   task automatic check_count(input string name, input stat_cnt_t got, input stat_cnt_t want);
      if (got !== want) report_mismatch(name, got, want);
   endtask

   // --------------------
   // pattern file.
   // --------------------
   task automatic load_patterns();
      int           fd;
      int           n;
      int           declared;
      string        line;
      test_desc_t   t;
      pkt_desc_t    p;
      logic [15:0]  mask;
      int           stall, npkt, words;
      logic [3:0]   dest, id;
      logic [7:0]   keep;
      logic [31:0]  seed;
      declared = 0;
      fd = $fopen("testbench/pkt_filter_patterns.txt", "r");
      if (fd == 0) end_with_failure("cannot open the pattern file");
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.substr(0, 0) == "T") begin
            n = $sscanf(line, "T %h %d %d", mask, stall, npkt);
            if (n != 3) end_with_failure("malformed test line in the pattern file");
            t.mask  = mask;
            t.stall = stall;
            t.npkt  = npkt;
            t.first = pkts.size();
            declared += npkt;
            tests.push_back(t);
         end else if (n > 0 && line.substr(0, 0) == "P") begin
            n = $sscanf(line, "P %h %h %d %h %h", dest, id, words, keep, seed);
            if (n != 5) end_with_failure("malformed packet line in the pattern file");
            p.dest      = dest;
            p.id        = id;
            p.words     = words;
            p.last_keep = keep;
            p.seed      = seed;
            total_words += words;
            pkts.push_back(p);
         end
      end
      $fclose(fd);
      if (declared != pkts.size()) end_with_failure("packet count in the pattern file is wrong");
   endtask

   // --------------------
   // stimulus.
   // --------------------
   function automatic pkt_data_t make_word(input logic [31:0] seed, input int idx);
      logic [31:0] lo;
      lo = seed + idx;
      return {~lo, lo};
   endfunction

   // present one word on the falling edge and hold it until it is taken.
   task automatic send_word(input pkt_data_t data, input pkt_keep_t keep, input logic last,
                            input pkt_id_t id, input pkt_dest_t dest, output longint stamp);
      in_tvalid = 1'b1;
      in_tdata  = data;
      in_tkeep  = keep;
      in_tlast  = last;
      in_tid    = id;
      in_tdest  = dest;
      do begin
         @(posedge clk);
      end while (in_tready !== 1'b1);
      stamp = $time;
      @(negedge clk);
      in_tvalid = 1'b0;
   endtask

   task automatic send_packet(input pkt_desc_t p);
      int         i;
      logic       blocked;
      logic       last;
      pkt_data_t  data;
      pkt_keep_t  keep;
      longint     stamp;
      exp_word_t  w;
      blocked = block_mask[p.dest];
      for (i = 0; i < p.words; i++) begin
         data = make_word(p.seed, i);
         last = (i == p.words - 1);
         keep = last ? p.last_keep : '1;
         send_word(data, keep, last, p.id, p.dest, stamp);
         if (blocked) begin
            exp_drop_bytes += $countones(keep);
         end else begin
            w = '{data, keep, last, p.id, p.dest, stamp};
            exp_q.push_back(w);
         end
         if ($urandom_range(3) == 0) begin
            repeat ($urandom_range(3, 1)) @(negedge clk);
         end
      end
      if (blocked) exp_drop_pkts += 1;
   endtask

   task automatic read_and_check(input stat_reg_t addr, input stat_cnt_t want,
                                 input string name);
      reg_rd   = 1'b1;
      reg_addr = addr;
      @(negedge clk);
      reg_rd = 1'b0;
      if (reg_rdata_valid !== 1'b1) begin
         end_with_failure("register read gave no reg_rdata_valid one cycle after reg_rd");
      end
      check_count(name, reg_rdata, want);
   endtask

   task automatic run_test(input test_desc_t t);
      int p;
      block_mask = t.mask;
      stall_pct  = t.stall;
      for (p = t.first; p < t.first + t.npkt; p++) begin
         send_packet(pkts[p]);
      end
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      // a dropped final word leaves the classify register one cycle after its transfer.
      repeat (2) @(negedge clk);
      read_and_check(REG_DROP_PKTS, exp_drop_pkts, "reg_rdata REG_DROP_PKTS");
      read_and_check(REG_DROP_BYTES, exp_drop_bytes, "reg_rdata REG_DROP_BYTES");
   endtask

   task automatic apply_backpressure();
      forever begin
         @(negedge clk);
         out_tready = ($urandom_range(99) >= stall_pct);
      end
   endtask

   task automatic watch_time(input int words);
      repeat (40 * words + 2000) @(posedge clk);
      end_with_failure("timeout, the run did not finish within its cycle budget");
   endtask

   // --------------------
   // scoreboard.
   // --------------------
   always @(posedge clk) begin : monitor
      exp_word_t w;
      if (!srst && out_tvalid && out_tready) begin
         if (exp_q.size() == 0) begin
            end_with_failure("unexpected output word while no word was expected");
         end else begin
            w = exp_q.pop_front();
            check_word(out_tdata, out_tkeep, out_tlast, out_tid, out_tdest, w);
            if ($time - w.stamp < 2 * CLK_PERIOD) begin
               end_with_failure("output word came out less than two cycles after its input");
            end
         end
      end
   end

   initial begin : main
      int t;
      void'($urandom(96826));
      srst           = 1'b1;
      in_tvalid      = 1'b0;
      in_tdata       = '0;
      in_tkeep       = '0;
      in_tlast       = 1'b0;
      in_tid         = '0;
      in_tdest       = '0;
      out_tready     = 1'b1;
      block_mask     = '0;
      reg_rd         = 1'b0;
      reg_addr       = REG_DROP_PKTS;
      stall_pct      = 0;
      total_words    = 0;
      exp_drop_pkts  = '0;
      exp_drop_bytes = '0;
      load_patterns();
      fork
         watch_time(total_words);
         apply_backpressure();
      join_none
      repeat (10) @(posedge clk);
      @(negedge clk);
      srst = 1'b0;
      for (t = 0; t < tests.size(); t++) begin
         run_test(tests[t]);
      end
      if (tests.size() > 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         end_with_failure("no tests were loaded from the pattern file");
      end
   end

endmodule
